/* dv/uart_input.txt */
# mode m (0 echo, 1 send) | rx byte stop | expect byte | greet count | wait cycles
# rx and expect bytes are hex, wait first lets every expected byte arrive
wait 2000
# Echo mode
expect 41
rx 41 1
expect 5a
rx 5a 1
expect 00
rx 00 1
expect ff
rx ff 1
expect a5
rx a5 1
wait 100
# Low stop bit, dropped and flagged
rx 3c 0
expect 7e
rx 7e 1
wait 100
# Send mode for two greetings
greet 2
mode 1
wait 100
mode 0
expect 12
rx 12 1
wait 100
# Back to echo while a greeting runs
greet 1
mode 1
mode 0
wait 100
expect c3
rx c3 1
expect 0d
rx 0d 1
wait 200

/* sim.f */
src/uart_pkg.sv
src/byte_stream_if.sv
src/uart_baud_gen.sv
src/uart_rx.sv
src/uart_tx.sv
src/uart_ioctl.sv
src/uart_top.sv
dv/uart_checker.sv
dv/tb_uart.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_uart
FILELIST  = sim.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

/* dv/tb_uart.sv */
`timescale 1ns/100ps

module tb_uart;

    localparam int CLKS_PER_BIT = 64;
    localparam int SEND_PERIOD  = 20000;
    localparam int DRAIN_LIMIT  = 50000;  // Enough cycles for two back to back greetings

    logic        clk;
    logic        rst;
    logic        mode;
    logic        rxd;
    logic        txd;
    logic        rx_error;
    logic        exp_push;
    logic [7:0]  exp_byte;
    logic        greet_push;
    logic        err_sent;
    logic        run_done;
    int          chk_errors;
    int          pending;
    int          tb_errors;
    logic [31:0] lfsr;

    uart_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .SEND_PERIOD  (SEND_PERIOD)
    ) uut (
        .clk      (clk),
        .rst      (rst),
        .mode     (mode),
        .rxd      (rxd),
        .txd      (txd),
        .rx_error (rx_error)
    );

    uart_checker #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) chk (
        .clk        (clk),
        .rst        (rst),
        .txd        (txd),
        .rx_error   (rx_error),
        .exp_push   (exp_push),
        .exp_byte   (exp_byte),
        .greet_push (greet_push),
        .err_sent   (err_sent),
        .run_done   (run_done),
        .errors     (chk_errors),
        .pending    (pending)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Holds rxd for one bit time
    task automatic drive_bit(input logic v);
        @(posedge clk);
        #5;
        rxd = v;
        repeat (CLKS_PER_BIT - 1) @(posedge clk);
    endtask

    task automatic send_byte(input logic [7:0] b, input logic stop);
        int gap;
        gap = 0;
        repeat (3) begin
            lfsr = lfsr_step(lfsr);
            gap  = gap * 2 + int'(lfsr[0]);
        end
        repeat (10 + gap) drive_bit(1'b1);  // At least one idle frame, so credits never run out
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++)
            drive_bit(b[i]);
        if (!stop)
            err_sent = 1'b1;
        drive_bit(stop);
        @(posedge clk);
        #5;
        rxd = 1'b1;
    endtask

    task automatic pulse_push(input logic greet, input logic [7:0] b);
        @(posedge clk);
        #5;
        exp_byte   = b;
        exp_push   = !greet;
        greet_push = greet;
        @(posedge clk);
        #5;
        exp_push   = 1'b0;
        greet_push = 1'b0;
    endtask

    task automatic set_mode(input logic v);
        @(posedge clk);
        #5;
        mode = v;
    endtask

    // Flags an input line that holds fewer values than its command takes
    task automatic check_arg_count(input int got, input int want,
                                   input logic [8*16-1:0] c);
        if (got != want) begin
            tb_errors++;
            $display("command %0s in the input file has %0d of its %0d values",
                     c, got, want);
        end
    endtask

    task automatic wait_drained(input int cycles);
        int n;
        n = 0;
        while (pending != 0 && n < DRAIN_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (pending != 0) begin
            tb_errors++;
            $display("timed out at %0d ns with %0d bytes still expected on txd",
                     $time, pending);
        end
        repeat (cycles) @(posedge clk);
    endtask

    initial begin
        int               fd;
        int               n;
        int               a;
        int               b;
        logic [8*16-1:0]  cmd;
        logic [8*128-1:0] line;

        rst        = 1'b1;
        mode       = 1'b0;
        rxd        = 1'b1;
        exp_push   = 1'b0;
        exp_byte   = 8'h00;
        greet_push = 1'b0;
        err_sent   = 1'b0;
        run_done   = 1'b0;
        tb_errors  = 0;
        lfsr       = 32'hf9ea8e5c;
        repeat (10) @(posedge clk);
        #5;
        rst = 1'b0;

        fd = $fopen("dv/uart_input.txt", "r");
        if (fd == 0) begin
            tb_errors++;
            $display("could not open dv/uart_input.txt");
        end else begin
            while ($fscanf(fd, "%s", cmd) == 1) begin
                if (cmd == "#") begin
                    n = $fgets(line, fd);
                end else if (cmd == "mode") begin
                    n = $fscanf(fd, "%d", a);
                    check_arg_count(n, 1, cmd);
                    set_mode(a[0]);
                end else if (cmd == "rx") begin
                    n = $fscanf(fd, "%h %h", a, b);
                    check_arg_count(n, 2, cmd);
                    send_byte(a[7:0], b[0]);
                end else if (cmd == "expect") begin
                    n = $fscanf(fd, "%h", a);
                    check_arg_count(n, 1, cmd);
                    pulse_push(1'b0, a[7:0]);
                end else if (cmd == "greet") begin
                    n = $fscanf(fd, "%d", a);
                    check_arg_count(n, 1, cmd);
                    repeat (a) pulse_push(1'b1, 8'h00);
                end else if (cmd == "wait") begin
                    n = $fscanf(fd, "%d", a);
                    check_arg_count(n, 1, cmd);
                    wait_drained(a);
                end else begin
                    tb_errors++;
                    $display("unknown command %0s in the input file", cmd);
                end
            end
            $fclose(fd);
        end

        wait_drained(200);
        @(posedge clk);
        #5;
        run_done = 1'b1;
        repeat (2) @(posedge clk);
        $display("errors: %0d from the checker, %0d from the testbench", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* dv/uart_checker.sv */
`timescale 1ns/100ps

module uart_checker import uart_pkg::*; #(
    parameter int CLKS_PER_BIT = 64
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  txd,
    input  logic  rx_error,
    input  logic  exp_push,    // Queue exp_byte
    input  byte_t exp_byte,
    input  logic  greet_push,  // Queue one whole greeting
    input  logic  err_sent,    // A frame with a low stop bit went out on rxd
    input  logic  run_done,
    output int    errors,
    output int    pending
);

    localparam int HALF = CLKS_PER_BIT / 2;

    byte_t exp_q [$];
    byte_t got;
    byte_t want;
    logic  busy;
    logic  rx_error_q;
    logic  done_seen = 1'b0;
    int    cnt;
    int    err_cnt = 0;
    int    q_len = 0;

    assign errors  = err_cnt;
    assign pending = q_len;

    // Sampling on the falling edge keeps clear of the DUT's register updates
    always @(negedge clk) begin
        if (exp_push)
            exp_q.push_back(exp_byte);
        if (greet_push) begin
            for (int i = 0; i < MSG_LEN; i++)
                exp_q.push_back(msg_text[i]);
        end

        if (rst) begin
            busy       = 1'b0;
            cnt        = 0;
            rx_error_q = rx_error;
        end else begin
            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            // Sticky error flag
            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            if (rx_error !== rx_error_q && rx_error !== err_sent) begin
                err_cnt++;
                $display("error at %0d ns: rx_error expected %b, got %b",
                         $time, err_sent, rx_error);
            end
            rx_error_q = rx_error;

            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            // Serial decode of txd
            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            if (!busy) begin
                if (txd === 1'b0) begin  // First low sample of a start bit
                    busy = 1'b1;
                    cnt  = 0;
                end
            end else begin
                cnt++;
                if (cnt == HALF && txd !== 1'b0) begin
                    err_cnt++;
                    $display("txd went low at %0d ns but was high again by mid-bit", $time);
                    busy = 1'b0;
                end else if (cnt > HALF && (cnt - HALF) % CLKS_PER_BIT == 0) begin
                    if ((cnt - HALF) / CLKS_PER_BIT <= 8) begin
                        got = {txd, got[7:1]};  // LSB first
                    end else begin
                        busy = 1'b0;
                        if (txd !== 1'b1) begin
                            err_cnt++;
                            $display("error at %0d ns: txd stop bit expected 1, got %b",
                                     $time, txd);
                        end
                        if (exp_q.size() == 0) begin
                            err_cnt++;
                            $display("byte %h appeared on txd at %0d ns with nothing expected",
                                     got, $time);
                        end else begin
                            want = exp_q.pop_front();
                            if (got !== want) begin
                                err_cnt++;
                                $display("error at %0d ns: txd byte expected %h, got %h",
                                         $time, want, got);
                            end
                        end
                    end
                end
            end

            if (run_done && !done_seen) begin
                done_seen = 1'b1;
                if (exp_q.size() != 0) begin
                    err_cnt++;
                    $display("%0d expected bytes never appeared on txd", exp_q.size());
                end
                if (rx_error !== err_sent) begin
                    err_cnt++;
                    $display("error at %0d ns: rx_error expected %b, got %b",
                             $time, err_sent, rx_error);
                end
            end
        end
        q_len = exp_q.size();
    end

endmodule

/* src/uart_top.sv */
`timescale 1ns/100ps

module uart_top #(
    parameter int CLKS_PER_BIT = 64,
    parameter int SEND_PERIOD  = 20000
) (
    input  logic clk,
    input  logic rst,
    input  logic mode,
    input  logic rxd,
    output logic txd,
    output logic rx_error
);

    logic tick;  // Oversampling strobe shared by both serial ends

    byte_stream_if rx_bus ();
    byte_stream_if tx_bus ();

    uart_baud_gen #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_baud_gen (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    uart_rx u_rx (
        .clk    (clk),
        .rst    (rst),
        .tick   (tick),
        .rxd    (rxd),
        .rx_bus (rx_bus.source)
    );

    uart_ioctl #(
        .SEND_PERIOD (SEND_PERIOD)
    ) u_ioctl (
        .clk      (clk),
        .rst      (rst),
        .mode     (mode),
        .rx_bus   (rx_bus.sink),
        .tx_bus   (tx_bus.source),
        .rx_error (rx_error)
    );

    uart_tx u_tx (
        .clk    (clk),
        .rst    (rst),
        .tick   (tick),
        .tx_bus (tx_bus.sink),
        .txd    (txd)
    );

endmodule

/* src/uart_ioctl.sv */
`timescale 1ns/100ps

module uart_ioctl import uart_pkg::*; #(
    parameter int SEND_PERIOD = 20000
) (
    input  logic clk,
    input  logic rst,
    input  logic mode,  // 0 echo, 1 send
    byte_stream_if.sink   rx_bus,
    byte_stream_if.source tx_bus,
    output logic rx_error
);

    localparam int CRW = $clog2(TX_DEPTH + 1);
    localparam int PCW = (SEND_PERIOD > 1) ? $clog2(SEND_PERIOD) : 1;
    localparam int IW  = $clog2(MSG_LEN);

    logic [CRW-1:0] credits;
    logic [PCW-1:0] period_cnt;
    logic [IW-1:0]  msg_idx;
    logic           sending;
    logic           has_credit;
    logic           start_msg;
    logic           echo_go;
    logic           msg_go;
    logic           spend;

    // The receiver cannot be held off, and the transmit path carries no errors
    assign rx_bus.credit = 1'b0;
    assign tx_bus.err    = 1'b0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Issue decisions
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Mode only matters while no greeting is running
    assign has_credit = (credits != '0);
    assign start_msg  = !sending && mode && (period_cnt == '0);
    assign echo_go    = !sending && !mode && rx_bus.valid && !rx_bus.err && has_credit;
    assign msg_go     = sending && has_credit;
    assign spend      = echo_go || msg_go;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits      <= CRW'(TX_DEPTH);
            period_cnt   <= '0;
            msg_idx      <= '0;
            sending      <= 1'b0;
            tx_bus.valid <= 1'b0;
            rx_error     <= 1'b0;
        end else begin
            tx_bus.valid <= spend;
            credits      <= credits - CRW'(spend) + CRW'(tx_bus.credit);

            if (start_msg) begin
                sending <= 1'b1;
                msg_idx <= '0;
            end else if (msg_go) begin
                msg_idx <= msg_idx + 1'b1;
                if (msg_idx == IW'(MSG_LEN - 1))
                    sending <= 1'b0;
            end

            // Period counter holds at zero in echo mode, so send mode starts at once
            if (sending || mode)
                period_cnt <= (period_cnt == PCW'(SEND_PERIOD - 1)) ? '0 : period_cnt + 1'b1;
            else
                period_cnt <= '0;

            if (rx_bus.valid && rx_bus.err)
                rx_error <= 1'b1;  // Sticky until reset
        end
    end

    always_ff @(posedge clk) begin
        if (echo_go)
            tx_bus.data <= rx_bus.data;
        else if (msg_go)
            tx_bus.data <= msg_text[msg_idx];
    end

    // Credits come back only for bytes already spent
    credit_bound: assert property (@(posedge clk) disable iff (rst)
        credits <= CRW'(TX_DEPTH))
        else $error("credit count %0d above TX_DEPTH", credits);

endmodule

/* src/uart_tx.sv */
`timescale 1ns/100ps

module uart_tx import uart_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic tick,
    byte_stream_if.sink tx_bus,
    output logic txd
);

    localparam int TW  = $clog2(OVERSAMPLE);
    localparam int PW  = (TX_DEPTH > 1) ? $clog2(TX_DEPTH) : 1;
    localparam int CNW = $clog2(TX_DEPTH + 1);

    byte_t          fifo_mem [TX_DEPTH];
    logic [PW-1:0]  wr_ptr;
    logic [PW-1:0]  rd_ptr;
    logic [CNW-1:0] count;
    logic           busy;
    logic [TW-1:0]  tick_cnt;
    logic [3:0]     bit_cnt;
    logic [8:0]     shift;  // Data bits then stop, start goes straight to txd
    logic           load;
    logic           bit_end;
    logic           last_bit;

    assign load     = tick && !busy && (count != '0);
    assign bit_end  = tick && busy && (tick_cnt == TW'(OVERSAMPLE - 1));
    assign last_bit = (bit_cnt == 4'd9);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            busy          <= 1'b0;
            tick_cnt      <= '0;
            bit_cnt       <= '0;
            txd           <= 1'b1;
            tx_bus.credit <= 1'b0;
        end else begin
            tx_bus.credit <= bit_end && last_bit;
            if (tx_bus.valid)
                wr_ptr <= (wr_ptr == PW'(TX_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (load)
                rd_ptr <= (rd_ptr == PW'(TX_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + CNW'(tx_bus.valid) - CNW'(load);
            if (load) begin
                busy     <= 1'b1;
                tick_cnt <= '0;
                bit_cnt  <= '0;
                txd      <= 1'b0;  // Start bit
            end else if (busy && tick) begin
                tick_cnt <= tick_cnt + 1'b1;
                if (bit_end) begin
                    if (last_bit) begin
                        busy <= 1'b0;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                        txd     <= shift[0];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tx_bus.valid)
            fifo_mem[wr_ptr] <= tx_bus.data;
        if (load)
            shift <= {1'b1, fifo_mem[rd_ptr]};
        else if (bit_end)
            shift <= {1'b1, shift[8:1]};
    end

    // A byte offered with the buffer full means the source overspent its credits
    credit_overrun: assert property (@(posedge clk) disable iff (rst)
        tx_bus.valid |-> count < CNW'(TX_DEPTH))
        else $error("tx_bus valid while transmit buffer full");

endmodule

/* src/uart_rx.sv */
`timescale 1ns/100ps

module uart_rx import uart_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic tick,
    input  logic rxd,
    byte_stream_if.source rx_bus
);

    localparam int TW = $clog2(OVERSAMPLE);

    localparam logic [2:0] S_IDLE     = 3'd0;
    localparam logic [2:0] S_START    = 3'd1;
    localparam logic [2:0] S_DATA     = 3'd2;
    localparam logic [2:0] S_STOP     = 3'd3;
    localparam logic [2:0] S_STOP_END = 3'd4;

    logic [2:0]    state;
    logic [TW-1:0] tick_cnt;
    logic [2:0]    bit_cnt;
    logic          rxd_s1;
    logic          rxd_s2;
    logic          rxd_s3;
    logic          fall;
    logic          stop_bit;
    byte_t         shift;
    logic          done;

    assign fall = rxd_s3 && !rxd_s2;

    // Stop bit ends half a bit after its sample, or early if the next start edge shows up
    assign done = (state == S_STOP_END) &&
                  (fall || (tick && tick_cnt == TW'(OVERSAMPLE / 2 - 1)));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rxd_s1       <= 1'b1;
            rxd_s2       <= 1'b1;
            rxd_s3       <= 1'b1;
            state        <= S_IDLE;
            tick_cnt     <= '0;
            bit_cnt      <= '0;
            rx_bus.valid <= 1'b0;
        end else begin
            rxd_s1       <= rxd;
            rxd_s2       <= rxd_s1;
            rxd_s3       <= rxd_s2;
            rx_bus.valid <= done;
            case (state)
                S_IDLE: begin
                    if (fall) begin
                        state    <= S_START;
                        tick_cnt <= '0;
                    end
                end
                S_START: begin
                    if (tick) begin
                        if (tick_cnt == TW'(OVERSAMPLE / 2 - 1)) begin
                            state    <= rxd_s2 ? S_IDLE : S_DATA;  // Glitch if already high
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                S_DATA, S_STOP: begin
                    if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;  // Wraps to zero at each mid-bit
                        if (tick_cnt == TW'(OVERSAMPLE - 1)) begin
                            if (state == S_STOP)
                                state <= S_STOP_END;
                            else if (bit_cnt == 3'd7)
                                state <= S_STOP;
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    if (done) begin
                        state    <= fall ? S_START : S_IDLE;
                        tick_cnt <= '0;
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (tick && tick_cnt == TW'(OVERSAMPLE - 1)) begin
            if (state == S_DATA)
                shift <= {rxd_s2, shift[7:1]};  // LSB arrives first
            else if (state == S_STOP)
                stop_bit <= rxd_s2;
        end
        if (done) begin
            rx_bus.data <= shift;
            rx_bus.err  <= !stop_bit;
        end
    end

    valid_pulse: assert property (@(posedge clk) disable iff (rst)
        rx_bus.valid |=> !rx_bus.valid)
        else $error("rx_bus valid held for more than one cycle");

endmodule

/* src/uart_baud_gen.sv */
`timescale 1ns/100ps

module uart_baud_gen import uart_pkg::*; #(
    parameter int CLKS_PER_BIT = 64
) (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam int DIV = CLKS_PER_BIT / OVERSAMPLE;
    localparam int CW  = (DIV > 1) ? $clog2(DIV) : 1;

    logic [CW-1:0] cnt;

    // Tick fires on every reload, so one pulse each DIV cycles
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt  <= CW'(DIV - 1);
            tick <= 1'b0;
        end else if (cnt == '0) begin
            cnt  <= CW'(DIV - 1);
            tick <= 1'b1;
        end else begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

    // Receiver and transmitter both assume a whole number of clocks per tick
    div_check: assert property (@(posedge clk) disable iff (rst)
        (CLKS_PER_BIT % OVERSAMPLE == 0) && (DIV >= 1))
        else $error("CLKS_PER_BIT %0d is not a nonzero multiple of %0d",
                    CLKS_PER_BIT, OVERSAMPLE);

endmodule

/* src/byte_stream_if.sv */
`timescale 1ns/100ps

interface byte_stream_if import uart_pkg::*; ();

    byte_t data;
    logic  valid;   // One cycle per byte
    logic  err;     // Qualified by valid
    logic  credit;  // One cycle per slot freed at the sink

    modport source (
        output data,
        output valid,
        output err,
        input  credit
    );

    modport sink (
        input  data,
        input  valid,
        input  err,
        output credit
    );

endinterface

/* src/uart_pkg.sv */
package uart_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Serial framing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int OVERSAMPLE = 16;  // Receiver and transmitter ticks per bit time
    localparam int TX_DEPTH   = 2;   // Transmit buffer entries, equal to the credits at reset

    typedef logic [7:0] byte_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Greeting text
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int MSG_LEN = 15;

    // Ends with carriage return and line feed
    localparam byte_t msg_text [MSG_LEN] = '{
        "H",
        "e",
        "l",
        "l",
        "o",
        ",",
        " ",
        "w",
        "o",
        "r",
        "l",
        "d",
        "!",
        8'h0d,
        8'h0a
    };

endpackage
